// File: verilog/hazardPkg.sv
package hazardPkg;

	// Major opcodes, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_JAL   = 6'b000011,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDI  = 6'b001000,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_LUI   = 6'b001111,
		OP_LB    = 6'b100000,
		OP_LH    = 6'b100001,
		OP_LW    = 6'b100011,
		OP_SB    = 6'b101000,
		OP_SH    = 6'b101001,
		OP_SW    = 6'b101011
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_JR    = 6'b001000,
		FN_MFHI  = 6'b010000,
		FN_MTHI  = 6'b010001,
		FN_MFLO  = 6'b010010,
		FN_MTLO  = 6'b010011,
		FN_MULT  = 6'b011000,
		FN_MULTU = 6'b011001,
		FN_DIV   = 6'b011010,
		FN_DIVU  = 6'b011011,
		FN_ADD   = 6'b100000,
		FN_SUB   = 6'b100010,
		FN_AND   = 6'b100100,
		FN_OR    = 6'b100101,
		FN_SLT   = 6'b101010,
		FN_SLTU  = 6'b101011
	} functT;

	// Cycle counts for Tuse and Tnew
	typedef logic [1:0] stageTimeT;
	typedef logic [4:0] regAddrT;

	localparam stageTimeT tCycle0 = 2'd0;
	localparam stageTimeT tCycle1 = 2'd1;
	localparam stageTimeT tCycle2 = 2'd2;

	// Where a decode operand is taken from
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_EXE  = 2'd1,
		FWD_MEM  = 2'd2
	} fwdSelT;

	localparam logic [31:0] nopWord = 32'h0000_0000;
	localparam regAddrT     linkReg = 5'd31;

endpackage

// File: verilog/useDecoder.sv
module useDecoder (
	input  logic [31:0]          instrD,
	output hazardPkg::regAddrT   rsD,
	output hazardPkg::regAddrT   rtD,
	output logic                 useRs,
	output logic                 useRt,
	output hazardPkg::stageTimeT tuseRs,
	output hazardPkg::stageTimeT tuseRt
);
	import hazardPkg::*;

	opcodeT opcode;
	functT  funct;

	assign opcode = opcodeT'(instrD[31:26]);
	assign funct  = functT'(instrD[5:0]);
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];

	////////////////////////////////////////////////////////////////////////////
	// Consumer table, which sources are read and how soon
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		useRs  = 1'b0;
		useRt  = 1'b0;
		tuseRs = tCycle0;
		tuseRt = tCycle0;
		case (opcode)
			// Compared in decode
			OP_BEQ, OP_BNE: begin
				useRs = 1'b1;
				useRt = 1'b1;
			end
			OP_RTYPE: begin
				case (funct)
					FN_JR: begin
						useRs = 1'b1;
					end
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
						useRs  = 1'b1;
						useRt  = 1'b1;
						tuseRs = tCycle1;
						tuseRt = tCycle1;
					end
					FN_MTHI, FN_MTLO: begin
						useRs  = 1'b1;
						tuseRs = tCycle1;
					end
					// mfhi, mflo and unknown functions read nothing
					default: ;
				endcase
			end
			OP_ORI, OP_ADDI, OP_ANDI, OP_LW, OP_LB, OP_LH: begin
				useRs  = 1'b1;
				tuseRs = tCycle1;
			end
			// Store data is only needed in memory
			OP_SW, OP_SB, OP_SH: begin
				useRs  = 1'b1;
				useRt  = 1'b1;
				tuseRs = tCycle1;
				tuseRt = tCycle2;
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/newDecoder.sv
module newDecoder #(
	parameter int stageOffset = 0
) (
	input  logic [31:0]          instr,
	output hazardPkg::stageTimeT tnew,
	output hazardPkg::regAddrT   dest
);
	import hazardPkg::*;

	localparam stageTimeT offset = stageTimeT'(stageOffset);

	opcodeT    opcode;
	functT     funct;
	regAddrT   rt;
	regAddrT   rd;
	stageTimeT tnewBase;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct  = functT'(instr[5:0]);
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	////////////////////////////////////////////////////////////////////////////
	// Producer table, Tnew as seen from execute
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		tnewBase = tCycle0;
		dest     = '0;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
					FN_MFHI, FN_MFLO: begin
						tnewBase = tCycle1;
						dest     = rd;
					end
					// Write HI/LO only
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
						tnewBase = tCycle1;
					end
					default: ;
				endcase
			end
			OP_ORI, OP_ADDI, OP_ANDI, OP_LUI: begin
				tnewBase = tCycle1;
				dest     = rt;
			end
			// Data comes back at the end of memory
			OP_LW, OP_LB, OP_LH: begin
				tnewBase = tCycle2;
				dest     = rt;
			end
			// Return address is known from the PC
			OP_JAL: begin
				tnewBase = tCycle0;
				dest     = linkReg;
			end
			// Stores, branches and j produce no register
			default: ;
		endcase
	end

	// Later stages are closer to having the result
	assign tnew = (tnewBase > offset) ? stageTimeT'(tnewBase - offset) : tCycle0;

endmodule

// File: verilog/stageTracker.sv
module stageTracker (
	input  logic        clk,
	input  logic        rstN,
	input  logic        stall,
	input  logic [31:0] instrD,
	output logic [31:0] instrE,
	output logic [31:0] instrM
);
	import hazardPkg::*;

	// Stall turns the execute slot into a bubble
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrE <= nopWord;
			instrM <= nopWord;
		end else begin
			instrM <= instrE;
			if (stall) begin
				instrE <= nopWord;
			end else begin
				instrE <= instrD;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pipeline checks
	////////////////////////////////////////////////////////////////////////////

	// A stalled instruction must not also enter execute
	bubbleOnStall: assert property (
		@(posedge clk) disable iff (!rstN)
		stall |=> (instrE == nopWord)
	) else $error("instrE is not a bubble after a stall cycle");

	// Memory always follows execute by one cycle
	memFollowsExe: assert property (
		@(posedge clk) disable iff (!rstN)
		1'b1 |=> (instrM == $past(instrE))
	) else $error("instrM differs from the previous instrE");

endmodule

// File: verilog/stallControl.sv
module stallControl (
	input  hazardPkg::regAddrT   rsD,
	input  hazardPkg::regAddrT   rtD,
	input  logic                 useRs,
	input  logic                 useRt,
	input  hazardPkg::stageTimeT tuseRs,
	input  hazardPkg::stageTimeT tuseRt,
	input  hazardPkg::stageTimeT tnewE,
	input  hazardPkg::stageTimeT tnewM,
	input  hazardPkg::regAddrT   destE,
	input  hazardPkg::regAddrT   destM,
	output logic                 stall
);

	// One operand against both producer stages
	function automatic logic operandStall(
		input hazardPkg::regAddrT   srcReg,
		input logic                 srcUsed,
		input hazardPkg::stageTimeT tuse
	);
		logic hitE;
		logic hitM;
		hitE = (srcReg == destE) && (tuse < tnewE);
		hitM = (srcReg == destM) && (tuse < tnewM);
		return srcUsed && (srcReg != '0) && (hitE || hitM);
	endfunction

	logic stallRs;
	logic stallRt;

	always_comb begin
		stallRs = operandStall(rsD, useRs, tuseRs);
		stallRt = operandStall(rtD, useRt, tuseRt);
		stall   = stallRs || stallRt;

		// $zero is hardwired, nothing can be pending on it
		zeroRegNoStall: assert ((useRs && rsD != '0) || (useRt && rtD != '0) || !stall)
			else $error("stall raised with no nonzero source register");
	end

endmodule

// File: verilog/forwardSelect.sv
module forwardSelect (
	input  hazardPkg::regAddrT   rsD,
	input  hazardPkg::regAddrT   rtD,
	input  logic                 useRs,
	input  logic                 useRt,
	input  hazardPkg::stageTimeT tnewE,
	input  hazardPkg::stageTimeT tnewM,
	input  hazardPkg::regAddrT   destE,
	input  hazardPkg::regAddrT   destM,
	output hazardPkg::fwdSelT    fwdRs,
	output hazardPkg::fwdSelT    fwdRt
);
	import hazardPkg::*;

	// Newest ready producer wins, so E is checked first
	function automatic fwdSelT pickSource(
		input regAddrT srcReg,
		input logic    srcUsed
	);
		logic live;
		live = srcUsed && (srcReg != '0);
		if (live && (srcReg == destE) && (tnewE == tCycle0)) begin
			return FWD_EXE;
		end else if (live && (srcReg == destM) && (tnewM == tCycle0)) begin
			return FWD_MEM;
		end
		return FWD_NONE;
	endfunction

	assign fwdRs = pickSource(rsD, useRs);
	assign fwdRt = pickSource(rtD, useRt);

endmodule

// File: verilog/hazardTop.sv
module hazardTop (
	input  logic              clk,
	input  logic              rstN,
	input  logic [31:0]       instrD,
	output logic              stall,
	output hazardPkg::fwdSelT fwdRs,
	output hazardPkg::fwdSelT fwdRt
);
	import hazardPkg::*;

	regAddrT     rsD;
	regAddrT     rtD;
	logic        useRs;
	logic        useRt;
	stageTimeT   tuseRs;
	stageTimeT   tuseRt;
	logic [31:0] instrE;
	logic [31:0] instrM;
	stageTimeT   tnewE;
	stageTimeT   tnewM;
	regAddrT     destE;
	regAddrT     destM;

	////////////////////////////////////////////////////////////////////////////
	// Consumer in decode, producers in execute and memory
	////////////////////////////////////////////////////////////////////////////
	useDecoder useDec (
		.instrD (instrD),
		.rsD    (rsD),
		.rtD    (rtD),
		.useRs  (useRs),
		.useRt  (useRt),
		.tuseRs (tuseRs),
		.tuseRt (tuseRt)
	);

	stageTracker tracker (
		.clk    (clk),
		.rstN   (rstN),
		.stall  (stall),
		.instrD (instrD),
		.instrE (instrE),
		.instrM (instrM)
	);

	newDecoder #(.stageOffset(0)) decodeExe (
		.instr (instrE),
		.tnew  (tnewE),
		.dest  (destE)
	);

	newDecoder #(.stageOffset(1)) decodeMem (
		.instr (instrM),
		.tnew  (tnewM),
		.dest  (destM)
	);

	stallControl stallCtl (
		.rsD    (rsD),
		.rtD    (rtD),
		.useRs  (useRs),
		.useRt  (useRt),
		.tuseRs (tuseRs),
		.tuseRt (tuseRt),
		.tnewE  (tnewE),
		.tnewM  (tnewM),
		.destE  (destE),
		.destM  (destM),
		.stall  (stall)
	);

	forwardSelect fwdSel (
		.rsD   (rsD),
		.rtD   (rtD),
		.useRs (useRs),
		.useRt (useRt),
		.tnewE (tnewE),
		.tnewM (tnewM),
		.destE (destE),
		.destM (destM),
		.fwdRs (fwdRs),
		.fwdRt (fwdRt)
	);

endmodule

// File: verification/clockGen.sv
module clockGen #(
	parameter int period = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// Half period low, half period high
	always begin
		#(period / 2);
		clk = ~clk;
	end

endmodule

// File: verification/hazardTb.sv
module hazardTb;
	import hazardPkg::*;

	localparam int resetCycles = 16;
	localparam int directedLen = 40;
	localparam int randomLen   = 300;
	// A load ahead of a branch holds one instruction for three cycles at most
	localparam int watchdogCycles = resetCycles + 3 * (directedLen + randomLen) + 50;

	logic        clk;
	logic        rstN;
	logic [31:0] instrD;
	logic        stall;
	fwdSelT      fwdRs;
	fwdSelT      fwdRt;

	// Reference copies of the execute and memory instructions
	logic [31:0] modelE;
	logic [31:0] modelM;
	logic [2:0]  needRs;
	logic [2:0]  needRt;
	logic [6:0]  prodE;
	logic [6:0]  prodM;
	logic        expStall;
	fwdSelT      expFwdRs;
	fwdSelT      expFwdRt;

	integer      seed;
	string       testName;
	int          testErrors;
	int          totalErrors;
	int          testsRun;
	int          testsBad;
	logic [5:0]  opPool [16];
	logic [5:0]  fnPool [16];

	clockGen #(.period(4)) clkGen (.clk(clk));

	hazardTop u_hazardTop (
		.clk    (clk),
		.rstN   (rstN),
		.instrD (instrD),
		.stall  (stall),
		.fwdRs  (fwdRs),
		.fwdRt  (fwdRt)
	);

	function automatic logic [31:0] enc(input logic [5:0] op, input logic [4:0] rs, rt, rd,
		input logic [5:0] fn);
		return {op, rs, rt, rd, 5'd0, fn};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// {reads, Tuse} of rs, or of rt when rtSide is set
	function automatic logic [2:0] readTime(input logic [31:0] instr, input logic rtSide);
		case (instr[31:26])
			OP_BEQ, OP_BNE: return 3'b100;
			OP_ORI, OP_ADDI, OP_ANDI, OP_LW, OP_LB, OP_LH: return rtSide ? 3'b000 : 3'b101;
			OP_SW, OP_SB, OP_SH: return rtSide ? 3'b110 : 3'b101;
			OP_RTYPE: begin
				case (instr[5:0])
					FN_JR: return rtSide ? 3'b000 : 3'b100;
					FN_MTHI, FN_MTLO: return rtSide ? 3'b000 : 3'b101;
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: return 3'b101;
					default: ;
				endcase
			end
			default: ;
		endcase
		return 3'b000;
	endfunction

	// {Tnew, dest} of a tracked instruction
	function automatic logic [6:0] produced(input logic [31:0] instr, input logic inMem);
		logic [1:0] tnew;
		logic [4:0] dest;
		tnew = 2'd0;
		dest = 5'd0;
		case (instr[31:26])
			OP_RTYPE: begin
				case (instr[5:0])
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU, FN_MFHI, FN_MFLO: begin
						tnew = 2'd1;
						dest = instr[15:11];
					end
					default: ;
				endcase
			end
			OP_ORI, OP_ADDI, OP_ANDI, OP_LUI: begin
				tnew = 2'd1;
				dest = instr[20:16];
			end
			OP_LW, OP_LB, OP_LH: begin
				tnew = 2'd2;
				dest = instr[20:16];
			end
			OP_JAL: dest = 5'd31;
			default: ;
		endcase
		if (inMem && tnew != 2'd0) begin
			tnew = tnew - 2'd1;
		end
		return {tnew, dest};
	endfunction

	function automatic logic mustStall(input logic [4:0] src, input logic [2:0] need,
		input logic [6:0] fromE, fromM);
		logic hitE;
		logic hitM;
		hitE = (fromE[4:0] == src) && (need[1:0] < fromE[6:5]);
		hitM = (fromM[4:0] == src) && (need[1:0] < fromM[6:5]);
		return need[2] && (src != 5'd0) && (hitE || hitM);
	endfunction

	function automatic fwdSelT source(input logic [4:0] src, input logic [2:0] need,
		input logic [6:0] fromE, fromM);
		if (!need[2] || src == 5'd0) begin
			return FWD_NONE;
		end
		if (fromE[4:0] == src && fromE[6:5] == 2'd0) begin
			return FWD_EXE;
		end
		if (fromM[4:0] == src && fromM[6:5] == 2'd0) begin
			return FWD_MEM;
		end
		return FWD_NONE;
	endfunction

	always_comb begin
		needRs   = readTime(instrD, 1'b0);
		needRt   = readTime(instrD, 1'b1);
		prodE    = produced(modelE, 1'b0);
		prodM    = produced(modelM, 1'b1);
		expStall = mustStall(instrD[25:21], needRs, prodE, prodM)
			|| mustStall(instrD[20:16], needRt, prodE, prodM);
		expFwdRs = source(instrD[25:21], needRs, prodE, prodM);
		expFwdRt = source(instrD[20:16], needRt, prodE, prodM);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			modelE <= nopWord;
			modelM <= nopWord;
		end else begin
			modelM <= modelE;
			modelE <= expStall ? nopWord : instrD;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////
	task automatic mismatch(input string what, input logic [1:0] expected,
		input logic [1:0] actual);
		testErrors++;
		$display("error %s: %s expected %0d, actual %0d", testName, what, expected, actual);
	endtask

	stallCheck: assert property (@(posedge clk) disable iff (!rstN) stall == expStall)
		else mismatch("stall", {1'b0, $sampled(expStall)}, {1'b0, $sampled(stall)});
	fwdRsCheck: assert property (@(posedge clk) disable iff (!rstN) fwdRs == expFwdRs)
		else mismatch("fwdRs", $sampled(expFwdRs), $sampled(fwdRs));
	fwdRtCheck: assert property (@(posedge clk) disable iff (!rstN) fwdRt == expFwdRt)
		else mismatch("fwdRt", $sampled(expFwdRt), $sampled(fwdRt));

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Hold the instruction in decode for as long as the DUT stalls
	task automatic issue(input logic [31:0] instr);
		logic held;
		instrD = instr;
		held = 1'b1;
		while (held) begin
			#1;
			held = stall;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finishTest();
		// Drain execute and memory
		issue(nopWord);
		issue(nopWord);
		testsRun++;
		if (testErrors == 0) begin
			$display("%s: pass", testName);
		end else begin
			testsBad++;
			$display("%s: %0d mismatches", testName, testErrors);
		end
		totalErrors += testErrors;
		testErrors = 0;
	endtask

	function automatic logic [4:0] randomReg(input logic [3:0] bits);
		return (bits == 4'hf) ? 5'd31 : {2'b00, bits[2:0]};
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [31:0] r;
		r = $random(seed);
		return enc(opPool[r[3:0]], randomReg(r[7:4]), randomReg(r[11:8]), randomReg(r[15:12]),
			fnPool[r[19:16]]);
	endfunction

	initial begin
		seed        = 32'h4f487d25;
		rstN        = 1'b0;
		// A load waits in decode while reset keeps execute and memory empty
		instrD      = enc(OP_LW, 5'd0, 5'd8, 5'd0, 6'd0);
		testName    = "reset";
		testErrors  = 0;
		totalErrors = 0;
		testsRun    = 0;
		testsBad    = 0;
		opPool = '{OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_ORI, OP_ADDI, OP_ANDI, OP_LUI,
			OP_LW, OP_LB, OP_LH, OP_SW, OP_SH, OP_BEQ, OP_JAL, OP_J};
		fnPool = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU, FN_JR, FN_MULT,
			FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO, FN_ADD};
		repeat (resetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;

		// First consumer sees empty execute and memory stages
		testName = "resetIdle";
		issue(enc(OP_BEQ, 5'd8, 5'd31, 5'd0, 6'd0));
		repeat (2) issue(nopWord);
		finishTest();

		// lw then a dependent add, then store data that waits for the load
		testName = "loadUse";
		issue(enc(OP_LW, 5'd1, 5'd5, 5'd0, 6'd0));
		issue(enc(OP_RTYPE, 5'd5, 5'd2, 5'd6, FN_ADD));
		issue(enc(OP_SW, 5'd6, 5'd5, 5'd0, 6'd0));
		finishTest();

		testName = "aluBranch";
		issue(enc(OP_ADDI, 5'd0, 5'd7, 5'd0, 6'd5));
		issue(enc(OP_BEQ, 5'd7, 5'd3, 5'd0, 6'd0));
		issue(enc(OP_ORI, 5'd0, 5'd3, 5'd0, 6'd1));
		issue(enc(OP_BNE, 5'd4, 5'd3, 5'd0, 6'd0));
		finishTest();

		// Second jal sits in E while the first is in M
		testName = "linkForward";
		issue(enc(OP_JAL, 5'd0, 5'd0, 5'd0, 6'd0));
		issue(enc(OP_RTYPE, 5'd31, 5'd0, 5'd0, FN_JR));
		issue(enc(OP_JAL, 5'd0, 5'd0, 5'd0, 6'd0));
		issue(enc(OP_JAL, 5'd0, 5'd0, 5'd0, 6'd0));
		issue(enc(OP_RTYPE, 5'd31, 5'd0, 5'd0, FN_JR));
		finishTest();

		// Fields that look like destinations but write nothing
		testName = "noProducer";
		issue(enc(OP_ADDI, 5'd1, 5'd0, 5'd0, 6'd1));
		issue(enc(OP_RTYPE, 5'd0, 5'd0, 5'd3, FN_ADD));
		issue(enc(OP_SW, 5'd1, 5'd4, 5'd4, 6'd0));
		issue(enc(OP_RTYPE, 5'd4, 5'd4, 5'd2, FN_ADD));
		issue(enc(OP_RTYPE, 5'd4, 5'd5, 5'd4, FN_MULT));
		issue(enc(OP_RTYPE, 5'd4, 5'd4, 5'd2, FN_ADD));
		issue(enc(OP_RTYPE, 5'd4, 5'd0, 5'd4, FN_MTHI));
		issue(enc(OP_RTYPE, 5'd4, 5'd4, 5'd2, FN_ADD));
		issue(enc(OP_J, 5'd31, 5'd31, 5'd31, 6'h3f));
		issue(enc(OP_RTYPE, 5'd31, 5'd0, 5'd0, FN_JR));
		finishTest();

		testName = "randomRun";
		repeat (randomLen) issue(randomInstr());
		finishTest();

		$display("tests %0d, with mismatches %0d, mismatches in total %0d",
			testsRun, testsBad, totalErrors);
		if (totalErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
		$display("test failed");
		$finish;
	end

endmodule

// File: tb.f
verilog/hazardPkg.sv
verilog/useDecoder.sv
verilog/newDecoder.sv
verilog/stageTracker.sv
verilog/stallControl.sv
verilog/forwardSelect.sv
verilog/hazardTop.sv
verification/clockGen.sv
verification/hazardTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module hazardTb -f tb.f -o hazardSim \
	&& ./obj_dir/hazardSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
